//--- files.f
+incdir+design
design/mmu_pkg.sv
design/tlb_way_ram.sv
design/tlb_maint.sv
design/tlb_lookup.sv
design/tlb_top.sv
testbench/tlb_tb.sv

//--- Makefile
# Verilator build and run of the tlb testbench

VERILATOR ?= verilator
TOP       ?= tlb_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= Checks failed

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard design/*.sv design/*.svh testbench/*.sv)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and grep $(LOG) for the fail message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tlb_tb.sv
// clock and reset, random stimulus, reference model, compare tasks, watchdog and summary for the tlb
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb_tb;

	localparam int N_WR      = 48;    // random writes that are each read back
	localparam int N_FILL_LK = 32;    // lookups into the boot region
	localparam int N_LK      = 200;   // lookups per random phase
	localparam int N_OPS     = 4 * `TLB_SETS + 2 * N_WR + N_FILL_LK + 2 * N_LK;

	logic                clk_g;
	logic                rst_i;
	logic                req_valid_i;
	logic                req_ready_o;
	mmu_pkg::tlb_req_t   req_i;
	logic                resp_valid_o;
	logic                resp_ready_i;
	mmu_pkg::tlb_resp_t  resp_o;
	logic                cmd_valid_i;
	logic                cmd_ready_o;
	mmu_pkg::tlb_cmd_t   cmd_i;
	logic                rd_valid_o;
	mmu_pkg::tlb_entry_t rd_entry_o;

	integer              seed;
	int                  cyc;           // counts rising edges
	int                  err_val;       // wrong values
	int                  err_proto;     // handshake and timing faults
	mmu_pkg::tlb_entry_t model [`TLB_WAYS][`TLB_SETS];
	mmu_pkg::tlb_resp_t  exp_q [$];     // expected responses in order
	int                  acc_q [$];     // acceptance cycle of each request
	mmu_pkg::way_t       wr_way [N_WR];
	mmu_pkg::tlb_idx_t   wr_idx [N_WR];

	tlb_top u_tlb_top (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.req_valid_i  (req_valid_i),
		.req_ready_o  (req_ready_o),
		.req_i        (req_i),
		.resp_valid_o (resp_valid_o),
		.resp_ready_i (resp_ready_i),
		.resp_o       (resp_o),
		.cmd_valid_i  (cmd_valid_i),
		.cmd_ready_o  (cmd_ready_o),
		.cmd_i        (cmd_i),
		.rd_valid_o   (rd_valid_o),
		.rd_entry_o   (rd_entry_o)
	);

	// ========================================
	// clock, cycle count, watchdog
	// ========================================
	initial begin
		clk_g = 1'b0;
		forever #4 clk_g = ~clk_g;   // 8 ns period
	end

	always @(posedge clk_g) cyc <= cyc + 1;

	initial begin
		repeat (N_OPS * 200 + `TLB_SETS + 4) @(posedge clk_g);
		$display("timeout: the testbench stopped waiting on a DUT handshake");
		$display("Checks failed");
		$finish;
	end

	// ========================================
	// compare tasks
	// ========================================
	task automatic check_resp(input string name, input mmu_pkg::tlb_resp_t exp,
	                          input mmu_pkg::tlb_resp_t act);
		if (exp !== act) begin
			err_val++;
			$display("error %s: expected %h, got %h", name, exp, act);
		end
	endtask

	task automatic check_entry(input string name, input mmu_pkg::tlb_entry_t exp,
	                           input mmu_pkg::tlb_entry_t act);
		if (exp !== act) begin
			err_val++;
			$display("error %s: expected %h, got %h", name, exp, act);
		end
	endtask

	// ========================================
	// reference model
	// ========================================
	// scan from the top way down so the first hit wins
	function automatic mmu_pkg::tlb_resp_t expect_resp(input mmu_pkg::tlb_req_t r);
		mmu_pkg::tlb_resp_t  e;
		mmu_pkg::tlb_entry_t m;
		int                  w;
		bit                  found;
		e     = '0;
		found = 1'b0;
		if (!r.xlat_en) begin
			e.paddr = r.vaddr;   // flat mapping with full rights
			e.acr   = 4'hf;
		end else begin
			for (w = `TLB_WAYS - 1; w >= 0; w--) begin
				m = model[w][r.vaddr[17:12]];
				if (!found && m.valid && m.tag == r.vaddr[31:18] &&
				    (m.glob || m.asid == r.asid)) begin
					found   = 1'b1;
					e.paddr = {m.ppn, r.vaddr[11:0]};
					e.acr   = r.sys_mode ? m.sacr : m.uacr;
				end
			end
			e.miss = ~found;   // paddr and acr stay zero
		end
		return e;
	endfunction

	// small tag, asid and index ranges so ways collide and hit often
	function automatic mmu_pkg::tlb_entry_t rand_entry();
		mmu_pkg::tlb_entry_t e;
		logic [31:0]         a;
		logic [31:0]         b;
		a      = $random(seed);
		b      = $random(seed);
		e.valid = |a[1:0];               // mostly valid
		e.glob  = a[2] & a[3];
		e.asid  = {6'b0, a[5:4]};
		e.tag   = {12'b0, a[7:6]};
		e.ppn   = a[27:8];
		e.uacr  = a[31:28];
		e.sacr  = b[3:0];
		return e;
	endfunction

	function automatic mmu_pkg::tlb_req_t rand_req(input bit boot_region);
		mmu_pkg::tlb_req_t r;
		logic [31:0]       a;
		a          = $random(seed);
		r.asid     = {6'b0, a[19:18]};
		r.sys_mode = a[20];
		if (boot_region) begin
			r.vaddr   = {14'h3fff, a[17:0]};   // top 256 KiB at any set
			r.xlat_en = 1'b1;
		end else begin
			r.vaddr   = {12'b0, a[1:0], 3'b0, a[4:2], a[16:5]};
			r.xlat_en = |a[23:21];             // one in eight passes through
		end
		return r;
	endfunction

	// ========================================
	// drivers
	// ========================================
	// each one is entered and left just after a rising edge
	task automatic send_cmd(input mmu_pkg::tlb_cmd_t c);
		cmd_i       = c;
		cmd_valid_i = 1'b1;
		@(negedge clk_g);
		if (!cmd_ready_o) begin
			err_proto++;
			$display("cmd_ready_o was low although the reset fill had ended");
		end
		while (!cmd_ready_o) @(negedge clk_g);
		if (c.we)
			model[c.way][c.index] = c.entry;   // takes effect at this edge
		@(posedge clk_g);
		#1;
		cmd_valid_i = 1'b0;
		if (!c.we) begin
			@(negedge clk_g);
			if (!rd_valid_o) begin
				err_proto++;
				$display("rd_valid_o did not rise one cycle after a read was accepted");
			end
			check_entry("rd_entry_o", model[c.way][c.index], rd_entry_o);
			@(negedge clk_g);
			if (rd_valid_o) begin
				err_proto++;
				$display("rd_valid_o stayed high for more than one cycle");
			end
			@(posedge clk_g);
			#1;
		end
	endtask

	// back-to-back requests with responses checked in order against the model
	task automatic run_lookups(input int n, input bit toggle_ready, input bit boot_region);
		int          sent;
		int          got;
		int          acc;
		bit          taken;
		logic [31:0] a;
		sent = 0;
		got  = 0;
		req_i       = rand_req(boot_region);
		req_valid_i = 1'b1;
		while (got < n) begin
			a            = $random(seed);
			resp_ready_i = toggle_ready ? a[0] : 1'b1;
			@(negedge clk_g);
			if (resp_valid_o && !resp_ready_i && req_ready_o) begin
				err_proto++;
				$display("req_ready_o stayed high while a response was held back");
			end
			taken = req_valid_i & req_ready_o;
			if (taken) begin
				exp_q.push_back(expect_resp(req_i));
				acc_q.push_back(cyc);
				sent++;
			end
			if (resp_valid_o && resp_ready_i) begin
				if (exp_q.size() == 0) begin
					err_proto++;
					$display("a response came out with no request outstanding");
				end else begin
					check_resp("resp_o", exp_q.pop_front(), resp_o);
					acc = acc_q.pop_front();
					if (!toggle_ready && cyc != acc + 2) begin
						err_proto++;
						$display("a response took %0d cycles instead of two", cyc - acc);
					end
				end
				got++;
			end
			@(posedge clk_g);
			#1;
			// payload only changes after its transfer
			if (taken) begin
				if (sent < n)
					req_i = rand_req(boot_region);
				else
					req_valid_i = 1'b0;
			end
		end
		resp_ready_i = 1'b1;
		if (exp_q.size() != 0) begin
			err_proto++;
			$display("requests were accepted but never answered");
		end
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial begin
		int                w;
		int                s;
		int                i;
		mmu_pkg::tlb_cmd_t c;
		logic [31:0]       a;
		seed         = 32'hb1db_7105;
		cyc          = 0;
		err_val      = 0;
		err_proto    = 0;
		rst_i        = 1'b1;
		req_valid_i  = 1'b0;
		req_i        = '0;
		resp_ready_i = 1'b1;
		cmd_valid_i  = 1'b0;
		cmd_i        = '0;
		// model starts out with the boot mapping in the last way
		for (w = 0; w < `TLB_WAYS; w++)
			for (s = 0; s < `TLB_SETS; s++)
				model[w][s] = '0;
		for (s = 0; s < `TLB_SETS; s++) begin
			model[`TLB_WAYS-1][s].valid = 1'b1;
			model[`TLB_WAYS-1][s].glob  = 1'b1;
			model[`TLB_WAYS-1][s].tag   = `FILL_TAG;
			model[`TLB_WAYS-1][s].ppn   = {`FILL_PPN_BASE, mmu_pkg::tlb_idx_t'(s)};
			model[`TLB_WAYS-1][s].uacr  = 4'hf;
			model[`TLB_WAYS-1][s].sacr  = 4'hf;
		end
		repeat (4) @(posedge clk_g);
		#1;
		rst_i = 1'b0;
		if (resp_valid_o || rd_valid_o || req_ready_o || cmd_ready_o) begin
			err_proto++;
			$display("an output valid or ready was high right after reset");
		end
		// nothing may be ready while the fill runs
		@(negedge clk_g);
		while (!cmd_ready_o) begin
			if (req_ready_o) begin
				err_proto++;
				$display("req_ready_o was high during the reset fill");
			end
			@(negedge clk_g);
		end
		@(posedge clk_g);
		#1;
		// the other ways power up unknown and are cleared first
		for (w = 0; w < `TLB_WAYS - 1; w++)
			for (s = 0; s < `TLB_SETS; s++) begin
				c       = '0;
				c.we    = 1'b1;
				c.way   = mmu_pkg::way_t'(w);
				c.index = mmu_pkg::tlb_idx_t'(s);
				send_cmd(c);
			end
		// read back and translate the boot mapping
		for (s = 0; s < `TLB_SETS; s++) begin
			c       = '0;
			c.way   = mmu_pkg::way_t'(`TLB_WAYS - 1);
			c.index = mmu_pkg::tlb_idx_t'(s);
			send_cmd(c);
		end
		run_lookups(N_FILL_LK, 1'b0, 1'b1);
		// random writes to the low sets followed by reads of the same places
		for (i = 0; i < N_WR; i++) begin
			a         = $random(seed);
			c.we      = 1'b1;
			c.way     = a[1:0];
			c.index   = {3'b0, a[4:2]};
			c.entry   = rand_entry();
			wr_way[i] = c.way;
			wr_idx[i] = c.index;
			send_cmd(c);
		end
		for (i = 0; i < N_WR; i++) begin
			c       = '0;
			c.way   = wr_way[i];
			c.index = wr_idx[i];
			send_cmd(c);
		end
		run_lookups(N_LK, 1'b0, 1'b0);   // fixed latency
		run_lookups(N_LK, 1'b1, 1'b0);   // consumer backpressure
		repeat (2) @(posedge clk_g);
		$display("summary: %0d value errors, %0d protocol errors", err_val, err_proto);
		if (err_val == 0 && err_proto == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

//--- design/tlb_top.sv
// tlb_top, way rams plus lookup pipeline and maintenance block
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb_top (
	input  logic                clk_g,
	input  logic                rst_i,
	// translation port
	input  logic                req_valid_i,
	output logic                req_ready_o,
	input  mmu_pkg::tlb_req_t   req_i,
	output logic                resp_valid_o,
	input  logic                resp_ready_i,
	output mmu_pkg::tlb_resp_t  resp_o,
	// maintenance port
	input  logic                cmd_valid_i,
	output logic                cmd_ready_o,
	input  mmu_pkg::tlb_cmd_t   cmd_i,
	output logic                rd_valid_o,
	output mmu_pkg::tlb_entry_t rd_entry_o
);

	// port A, maintenance side
	logic                                a_en;
	logic [`TLB_WAYS-1:0]                a_we;      // one-hot way select
	mmu_pkg::tlb_idx_t                   a_idx;
	mmu_pkg::tlb_entry_t                 a_wdata;
	mmu_pkg::tlb_entry_t [`TLB_WAYS-1:0] a_rdata;
	// port B, lookup side
	logic                                b_en;
	mmu_pkg::tlb_idx_t                   b_idx;
	mmu_pkg::tlb_entry_t [`TLB_WAYS-1:0] b_rdata;
	logic                                fill_busy;

	// ========================================
	// way rams
	// ========================================
	for (genvar g = 0; g < `TLB_WAYS; g++) begin : g_way
		tlb_way_ram u_way_ram (
			.clk_g     (clk_g),
			.a_en_i    (a_en),
			.a_we_i    (a_we[g]),
			.a_idx_i   (a_idx),
			.a_wdata_i (a_wdata),
			.a_rdata_o (a_rdata[g]),
			.b_en_i    (b_en),
			.b_idx_i   (b_idx),
			.b_rdata_o (b_rdata[g])
		);
	end

	tlb_lookup u_lookup (
		.clk_g        (clk_g),
		.rst_i        (rst_i),
		.fill_busy_i  (fill_busy),
		.req_valid_i  (req_valid_i),
		.req_ready_o  (req_ready_o),
		.req_i        (req_i),
		.resp_valid_o (resp_valid_o),
		.resp_ready_i (resp_ready_i),
		.resp_o       (resp_o),
		.ram_en_o     (b_en),
		.ram_idx_o    (b_idx),
		.ram_rdata_i  (b_rdata)
	);

	tlb_maint u_maint (
		.clk_g       (clk_g),
		.rst_i       (rst_i),
		.cmd_valid_i (cmd_valid_i),
		.cmd_ready_o (cmd_ready_o),
		.cmd_i       (cmd_i),
		.rd_valid_o  (rd_valid_o),
		.rd_entry_o  (rd_entry_o),
		.fill_busy_o (fill_busy),
		.ram_en_o    (a_en),
		.ram_we_o    (a_we),
		.ram_idx_o   (a_idx),
		.ram_wdata_o (a_wdata),
		.ram_rdata_i (a_rdata)
	);

endmodule

//--- design/tlb_lookup.sv
// tlb_lookup, two-stage translation pipeline on ram port B with result register
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb_lookup (
	input  logic                                clk_g,
	input  logic                                rst_i,
	input  logic                                fill_busy_i,
	// request side
	input  logic                                req_valid_i,
	output logic                                req_ready_o,
	input  mmu_pkg::tlb_req_t                   req_i,
	// response side
	output logic                                resp_valid_o,
	input  logic                                resp_ready_i,
	output mmu_pkg::tlb_resp_t                  resp_o,
	// port B of every way
	output logic                                ram_en_o,
	output mmu_pkg::tlb_idx_t                   ram_idx_o,
	input  mmu_pkg::tlb_entry_t [`TLB_WAYS-1:0] ram_rdata_i
);

	logic                stall;        // response waiting on the consumer
	logic                req_acc;
	logic                s1_valid_q;
	mmu_pkg::tlb_req_t   s1_req_q;     // request whose entries are on port B
	logic                hit;
	mmu_pkg::tlb_entry_t hit_e;        // winning entry
	mmu_pkg::tlb_resp_t  resp_d;

	// ========================================
	// handshake
	// ========================================
	assign stall       = resp_valid_o & ~resp_ready_i;
	assign req_ready_o = ~fill_busy_i & ~stall;   // no lookups until the boot map is in
	assign req_acc     = req_valid_i & req_ready_o;

	// ram reads in parallel with stage one, held low while stalled
	assign ram_en_o  = req_acc;
	assign ram_idx_o = req_i.vaddr[17:12];

	// ========================================
	// stage one, capture request
	// ========================================
	always_ff @(posedge clk_g) begin
		if (rst_i)
			s1_valid_q <= 1'b0;
		else if (!stall)
			s1_valid_q <= req_acc;
	end

	always_ff @(posedge clk_g) begin
		if (req_acc)
			s1_req_q <= req_i;
	end

	// ========================================
	// stage two, compare and form result
	// ========================================
	// later ways override, so the highest numbered hit wins
	always_comb begin
		int w;
		hit   = 1'b0;
		hit_e = '0;
		for (w = 0; w < `TLB_WAYS; w++) begin
			if (ram_rdata_i[w].valid &&
			    ram_rdata_i[w].tag == mmu_pkg::vtag_t'(s1_req_q.vaddr[31:18]) &&
			    (ram_rdata_i[w].glob || ram_rdata_i[w].asid == s1_req_q.asid)) begin
				hit   = 1'b1;
				hit_e = ram_rdata_i[w];
			end
		end
	end

	always_comb begin
		resp_d = '0;   // miss leaves paddr and acr at zero
		if (!s1_req_q.xlat_en) begin
			resp_d.paddr = s1_req_q.vaddr;   // translation off, flat mapping
			resp_d.acr   = 4'hf;
		end else if (hit) begin
			resp_d.paddr = {hit_e.ppn, s1_req_q.vaddr[11:0]};
			resp_d.acr   = s1_req_q.sys_mode ? hit_e.sacr : hit_e.uacr;
		end else begin
			resp_d.miss = 1'b1;
		end
	end

	// result register, frozen together with stage one
	always_ff @(posedge clk_g) begin
		if (rst_i)
			resp_valid_o <= 1'b0;
		else if (!stall)
			resp_valid_o <= s1_valid_q;
	end

	always_ff @(posedge clk_g) begin
		if (!stall && s1_valid_q)
			resp_o <= resp_d;
	end

endmodule

//--- design/tlb_maint.sv
// tlb_maint, power-up fill sequencer and software read/write port on ram port A
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb_maint (
	input  logic                                clk_g,
	input  logic                                rst_i,
	// command port
	input  logic                                cmd_valid_i,
	output logic                                cmd_ready_o,
	input  mmu_pkg::tlb_cmd_t                   cmd_i,
	// read-back, one cycle after the read is accepted
	output logic                                rd_valid_o,
	output mmu_pkg::tlb_entry_t                 rd_entry_o,
	// holds the lookup off until the boot mapping exists
	output logic                                fill_busy_o,
	// port A of every way
	output logic                                ram_en_o,
	output logic [`TLB_WAYS-1:0]                ram_we_o,
	output mmu_pkg::tlb_idx_t                   ram_idx_o,
	output mmu_pkg::tlb_entry_t                 ram_wdata_o,
	input  mmu_pkg::tlb_entry_t [`TLB_WAYS-1:0] ram_rdata_i
);

	mmu_pkg::maint_state_t state_q;
	mmu_pkg::tlb_idx_t     fill_cnt_q;   // set being filled
	mmu_pkg::tlb_entry_t   fill_entry;
	logic                  cmd_acc;      // command handshake
	logic                  rd_pend_q;    // read issued last cycle
	mmu_pkg::way_t         rd_way_q;     // way to return

	assign cmd_ready_o = (state_q == mmu_pkg::ST_RUN);   // always ready once running
	assign cmd_acc     = cmd_valid_i & cmd_ready_o;
	assign fill_busy_o = (state_q == mmu_pkg::ST_FILL);

	// ========================================
	// fill fsm
	// ========================================
	// one set per cycle, TLB_SETS cycles then run
	always_ff @(posedge clk_g) begin
		if (rst_i) begin
			state_q    <= mmu_pkg::ST_FILL;
			fill_cnt_q <= '0;
		end else begin
			case (state_q)
				mmu_pkg::ST_FILL: begin
					fill_cnt_q <= fill_cnt_q + 1'b1;
					if (fill_cnt_q == mmu_pkg::tlb_idx_t'(`TLB_SETS - 1))
						state_q <= mmu_pkg::ST_RUN;   // last set written this cycle
				end
				default: state_q <= mmu_pkg::ST_RUN;   // stays here until reset
			endcase
		end
	end

	// boot mapping, identity on the top region
	always_comb begin
		fill_entry       = '0;
		fill_entry.valid = 1'b1;
		fill_entry.glob  = 1'b1;                          // matches any asid
		fill_entry.tag   = `FILL_TAG;
		fill_entry.ppn   = {`FILL_PPN_BASE, fill_cnt_q};  // index gives the low ppn bits
		fill_entry.uacr  = 4'hf;
		fill_entry.sacr  = 4'hf;
	end

	// ========================================
	// port A drive
	// ========================================
	always_comb begin
		int w;
		ram_we_o = '0;
		if (state_q == mmu_pkg::ST_FILL) begin
			ram_en_o                 = 1'b1;
			ram_we_o[`TLB_WAYS-1]    = 1'b1;   // fill goes to the last way only
			ram_idx_o                = fill_cnt_q;
			ram_wdata_o              = fill_entry;
		end else begin
			ram_en_o    = cmd_acc;        // reads and writes both need the port
			ram_idx_o   = cmd_i.index;
			ram_wdata_o = cmd_i.entry;
			// software names the way, decode to one-hot
			for (w = 0; w < `TLB_WAYS; w++)
				ram_we_o[w] = cmd_acc & cmd_i.we & (cmd_i.way == mmu_pkg::way_t'(w));
		end
	end

	// ========================================
	// read-back
	// ========================================
	always_ff @(posedge clk_g) begin
		if (rst_i)
			rd_pend_q <= 1'b0;
		else
			rd_pend_q <= cmd_acc & ~cmd_i.we;   // single cycle pulse per read
	end

	always_ff @(posedge clk_g) begin
		if (cmd_acc)
			rd_way_q <= cmd_i.way;   // ram data lands next cycle, pick it then
	end

	assign rd_valid_o = rd_pend_q;
	assign rd_entry_o = ram_rdata_i[rd_way_q];

endmodule

//--- design/tlb_way_ram.sv
// tlb_way_ram, read-first true dual-port ram holding one way of entries
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb_way_ram (
	input  logic                clk_g,
	// port A, maintenance side
	input  logic                a_en_i,
	input  logic                a_we_i,
	input  mmu_pkg::tlb_idx_t   a_idx_i,
	input  mmu_pkg::tlb_entry_t a_wdata_i,
	output mmu_pkg::tlb_entry_t a_rdata_o,
	// port B, lookup side, read only
	input  logic                b_en_i,
	input  mmu_pkg::tlb_idx_t   b_idx_i,
	output mmu_pkg::tlb_entry_t b_rdata_o
);

	mmu_pkg::tlb_entry_t mem [0:`TLB_SETS-1];   // entry storage

	// ========================================
	// port A
	// ========================================
	always_ff @(posedge clk_g) begin
		if (a_en_i) begin
			a_rdata_o <= mem[a_idx_i];   // old data on a same-address write
			if (a_we_i)
				mem[a_idx_i] <= a_wdata_i;
		end
	end

	// ========================================
	// port B
	// ========================================
	// output holds while the enable is low, the lookup relies on it when stalled
	always_ff @(posedge clk_g) begin
		if (b_en_i)
			b_rdata_o <= mem[b_idx_i];
	end

endmodule

//--- design/mmu_pkg.sv
// tlb width typedefs, entry layout, port structs and maintenance fsm states
`include "mmu_defs.svh"

package mmu_pkg;

	// ========================================
	// widths with a meaning
	// ========================================
	typedef logic [31:0] vaddr_t;                // virtual address, 4 KiB pages
	typedef logic [31:0] paddr_t;                // physical address
	typedef logic [7:0] asid_t;                  // address space id
	typedef logic [13:0] vtag_t;                 // vaddr[31:18]
	typedef logic [19:0] ppn_t;                  // physical page number
	typedef logic [`TLB_IDX_W-1:0] tlb_idx_t;    // vaddr[17:12]
	typedef logic [1:0] way_t;                   // way number
	typedef logic [3:0] acr_t;                   // {cacheable, read, write, execute}

	// one tlb entry, 52 bits
	typedef struct packed {
		logic  valid;
		logic  glob;     // global page, asid ignored
		asid_t asid;
		vtag_t tag;
		ppn_t  ppn;
		acr_t  uacr;     // user mode rights
		acr_t  sacr;     // system mode rights
	} tlb_entry_t;

	// translation request
	typedef struct packed {
		vaddr_t vaddr;
		asid_t  asid;
		logic   sys_mode;   // selects sacr over uacr
		logic   xlat_en;    // low passes the address through
	} tlb_req_t;

	// translation response
	typedef struct packed {
		paddr_t paddr;
		acr_t   acr;
		logic   miss;
	} tlb_resp_t;

	// maintenance command, read when we is low
	typedef struct packed {
		logic       we;
		way_t       way;
		tlb_idx_t   index;
		tlb_entry_t entry;
	} tlb_cmd_t;

	typedef enum logic {
		ST_FILL,   // power-up fill of the last way
		ST_RUN     // software commands
	} maint_state_t;

endpackage

//--- design/mmu_defs.svh
// tlb geometry and power-up fill constants
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// ========================================
// geometry
// ========================================
`define TLB_WAYS 4                     // ways, each one dual-port ram
`define TLB_SETS 64                    // sets per way
`define TLB_IDX_W 6                    // log2 of TLB_SETS

// ========================================
// power-up fill of the last way
// ========================================
// maps the top 256 KiB of the address space onto itself
`define FILL_PPN_BASE 14'h3fff         // upper ppn bits, set index fills the rest
`define FILL_TAG 14'h3fff              // vaddr[31:18] of the boot region

`endif
